// ==== compile.f ====
rtl/rop_pkg.sv
rtl/rop_cache_if.sv
rtl/rop_addr_gen.sv
rtl/rop_mem_streamer.sv
rtl/rop_mem.sv
rtl/rop_mem_top.sv
bench/rop_cache_model.sv
bench/rop_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rop_mem_tb
RTL_TOP   ?= rop_mem_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/rop_mem_tb.sv ====
module rop_mem_tb
    import rop_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NL          = 4;
    localparam int QUAD_CYCLES = 200;

    typedef struct {
        logic        rw;
        logic [3:0]  tmask;
        logic [15:0] x0;
        logic [15:0] y0;
        logic [31:0] color;
        logic [23:0] depth;
        logic [7:0]  stencil;
        logic [3:0]  tag;
        logic [3:0]  cmask;
        logic        dmask;
        logic        smask;
        int          cfg;
        int          stall;
    } entry_t;

    logic                    clk = 1'b0;
    logic                    arst_n;
    rop_dcrs_t               dcrs;
    logic                    req_valid;
    logic [NL-1:0]           req_tmask;
    logic                    req_rw;
    logic [NL-1:0][15:0]     req_pos_x;
    logic [NL-1:0][15:0]     req_pos_y;
    rgba_t [NL-1:0]          req_color;
    logic [NL-1:0][23:0]     req_depth;
    logic [NL-1:0][7:0]      req_stencil;
    logic [3:0]              req_tag;
    logic                    req_ready;
    logic                    rsp_valid;
    logic [NL-1:0]           rsp_tmask;
    rgba_t [NL-1:0]          rsp_color;
    logic [NL-1:0][23:0]     rsp_depth;
    logic [NL-1:0][7:0]      rsp_stencil;
    logic [3:0]              rsp_tag;
    logic                    rsp_ready;
    logic                    c_req_valid;
    logic                    c_req_rw;
    logic [3:0]              c_req_byteen;
    logic [31:0]             c_req_addr;
    logic [31:0]             c_req_data;
    logic [3:0]              c_req_tag;
    logic                    c_req_ready;
    logic                    c_rsp_valid;
    logic [31:0]             c_rsp_data;
    logic [3:0]              c_rsp_tag;
    logic                    c_rsp_ready;

    entry_t      tbl[$];
    logic [31:0] shadow [logic [31:0]];
    bit          allowed [logic [31:0]];
    int          access_cnt;
    int          errors;
    int          checks;
    bit          table_built;

    always #4 clk = ~clk;

    rop_mem_top #(.NUM_LANES(NL), .TAG_WIDTH(4)) UUT (
        .clk(clk), .arst_n(arst_n), .dcrs(dcrs),
        .req_valid(req_valid), .req_tmask(req_tmask), .req_rw(req_rw),
        .req_pos_x(req_pos_x), .req_pos_y(req_pos_y), .req_color(req_color),
        .req_depth(req_depth), .req_stencil(req_stencil), .req_tag(req_tag),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp_tmask(rsp_tmask), .rsp_color(rsp_color),
        .rsp_depth(rsp_depth), .rsp_stencil(rsp_stencil), .rsp_tag(rsp_tag),
        .rsp_ready(rsp_ready),
        .cache_req_valid(c_req_valid), .cache_req_rw(c_req_rw),
        .cache_req_byteen(c_req_byteen), .cache_req_addr(c_req_addr),
        .cache_req_data(c_req_data), .cache_req_tag(c_req_tag),
        .cache_req_ready(c_req_ready),
        .cache_rsp_valid(c_rsp_valid), .cache_rsp_data(c_rsp_data),
        .cache_rsp_tag(c_rsp_tag), .cache_rsp_ready(c_rsp_ready)
    );

    rop_cache_model #(.TAG_WIDTH(4)) cache_model (
        .clk(clk), .arst_n(arst_n),
        .req_valid(c_req_valid), .req_rw(c_req_rw), .req_byteen(c_req_byteen),
        .req_addr(c_req_addr), .req_data(c_req_data), .req_tag(c_req_tag),
        .req_ready(c_req_ready), .rsp_valid(c_rsp_valid), .rsp_data(c_rsp_data),
        .rsp_tag(c_rsp_tag), .rsp_ready(c_rsp_ready)
    );

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic add_entry(input logic rw, input logic [3:0] tmask, input int x0,
                             input int y0, input logic [31:0] color, input logic [23:0] depth,
                             input logic [7:0] stencil, input logic [3:0] tag,
                             input logic [3:0] cmask, input logic dmask, input logic smask,
                             input int cfg, input int stall);
        entry_t e;
        e = '{rw, tmask, 16'(x0), 16'(y0), color, depth, stencil, tag,
              cmask, dmask, smask, cfg, stall};
        tbl.push_back(e);
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] waddr);
        return (waddr * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        return shadow.exists(addr >> 2) ? shadow[addr >> 2] : fill_word(addr >> 2);
    endfunction

    // Byte-masked update of one shadow word
    task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] be);
        logic [31:0] word;
        word = shadow_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        shadow[addr >> 2] = word;
    endtask

    // Every issued access must belong to an active lane of the current quad
    always @(posedge clk) begin
        if (arst_n && c_req_valid && c_req_ready) begin
            access_cnt++;
            if (!allowed.exists(c_req_addr)) begin
                errors++;
                $display("unexpected cache access at address %h", c_req_addr);
            end
        end
    end

    // All response fields against the predicted quad
    task automatic compare_quad(input entry_t e, input rgba_t [NL-1:0] exp_color,
                                input logic [NL-1:0][23:0] exp_depth,
                                input logic [NL-1:0][7:0] exp_stencil);
        check("rsp_tag", 64'(rsp_tag), 64'(e.tag));
        check("rsp_tmask", 64'(rsp_tmask), 64'(e.tmask));
        for (int i = 0; i < NL; i++) begin
            check($sformatf("rsp_color[%0d]", i), 64'(rsp_color[i]), 64'(exp_color[i]));
            check($sformatf("rsp_depth[%0d]", i), 64'(rsp_depth[i]), 64'(exp_depth[i]));
            check($sformatf("rsp_stencil[%0d]", i), 64'(rsp_stencil[i]),
                  64'(exp_stencil[i]));
        end
    endtask

    task automatic run_quad(input entry_t e);
        logic [31:0] caddr;
        logic [31:0] zaddr;
        logic [31:0] word;
        rgba_t [NL-1:0]      exp_color;
        logic [NL-1:0][23:0] exp_depth;
        logic [NL-1:0][7:0]  exp_stencil;
        int                  wait_cnt;
        @(negedge clk);
        dcrs.cbuf_addr  = (e.cfg == 0) ? 32'h0000_1000 : 32'h0002_0000;
        dcrs.cbuf_pitch = (e.cfg == 0) ? 16'd64 : 16'd37;
        dcrs.zbuf_addr  = (e.cfg == 0) ? 32'h0000_8000 : 32'h0003_0400;
        dcrs.zbuf_pitch = (e.cfg == 0) ? 16'd64 : 16'd100;
        dcrs.cbuf_writemask         = e.cmask;
        dcrs.zbuf_depth_writemask   = e.dmask;
        dcrs.zbuf_stencil_writemask = e.smask;
        allowed.delete();
        access_cnt = 0;
        for (int i = 0; i < NL; i++) begin
            req_pos_x[i]   = e.x0 + 16'(i & 1);
            req_pos_y[i]   = e.y0 + 16'(i >> 1);
            req_color[i]   = e.color + 32'(i) * 32'h0102_0304;
            req_depth[i]   = e.depth + 24'(i) * 24'h01_0203;
            req_stencil[i] = e.stencil + 8'(i);
            caddr = dcrs.cbuf_addr + 4 * (32'(req_pos_y[i]) * dcrs.cbuf_pitch + req_pos_x[i]);
            zaddr = dcrs.zbuf_addr + 4 * (32'(req_pos_y[i]) * dcrs.zbuf_pitch + req_pos_x[i]);
            exp_color[i]   = '0;
            exp_depth[i]   = '0;
            exp_stencil[i] = '0;
            if (e.tmask[i]) begin
                allowed[caddr] = 1'b1;
                allowed[zaddr] = 1'b1;
                if (e.rw) begin
                    shadow_write(caddr, req_color[i], e.cmask);
                    shadow_write(zaddr, {req_stencil[i], req_depth[i]},
                                 {e.smask, {3{e.dmask}}});
                end else begin
                    exp_color[i]   = shadow_read(caddr);
                    word           = shadow_read(zaddr);
                    exp_depth[i]   = word[23:0];
                    exp_stencil[i] = word[31:24];
                end
            end
        end
        req_rw    = e.rw;
        req_tmask = e.tmask;
        req_tag   = e.tag;
        req_valid = 1'b1;
        rsp_ready = (e.stall == 0);
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        wait_cnt  = 0;
        while (!rsp_valid && wait_cnt < QUAD_CYCLES) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!rsp_valid) begin
            errors++;
            $display("no response for quad with tag %h", e.tag);
            return;
        end
        check("cache accesses", 64'(access_cnt), 64'(2 * $countones(e.tmask)));
        compare_quad(e, exp_color, exp_depth, exp_stencil);
        // Stalled consumer, response must hold and no new quad is taken
        repeat (e.stall) begin
            @(negedge clk);
            check("rsp_valid", 64'(rsp_valid), 64'(1'b1));
            check("req_ready", 64'(req_ready), 64'(1'b0));
            compare_quad(e, exp_color, exp_depth, exp_stencil);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        check("rsp_valid", 64'(rsp_valid), 64'(1'b0));
    endtask

    initial begin
        wait (table_built);
        #((20 + tbl.size() * QUAD_CYCLES) * 8);
        $display("simulation timed out before all quads completed");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        arst_n = 1'b0;
        dcrs = '0;
        req_valid = 1'b0;
        req_tmask = '0;
        req_rw = 1'b0;
        req_pos_x = '0;
        req_pos_y = '0;
        req_color = '0;
        req_depth = '0;
        req_stencil = '0;
        req_tag = '0;
        rsp_ready = 1'b1;
        // rw tmask x y color depth stencil tag cmask dm sm cfg stall
        add_entry(1, 4'hF, 4, 2, 32'h1122_3344, 24'h0A_BCDE, 8'h5A, 4'h1, 4'hF, 1, 1, 0, 0);
        add_entry(0, 4'hF, 4, 2, 0, 0, 0, 4'h2, 4'hF, 1, 1, 0, 0);
        add_entry(1, 4'hF, 4, 2, 32'hCAFE_F00D, 24'h12_3456, 8'hC3, 4'h3, 4'h5, 1, 0, 0, 0);
        add_entry(0, 4'hF, 4, 2, 0, 0, 0, 4'h4, 4'hF, 1, 1, 0, 3);
        add_entry(1, 4'h9, 10, 6, 32'hA0B0_C0D0, 24'h77_0011, 8'h19, 4'h5, 4'hF, 1, 1, 0, 0);
        add_entry(0, 4'hF, 10, 6, 0, 0, 0, 4'h6, 4'hF, 1, 1, 0, 0);
        add_entry(0, 4'h0, 20, 20, 0, 0, 0, 4'h7, 4'hF, 1, 1, 0, 2);
        add_entry(1, 4'hF, 3, 9, 32'h0F1E_2D3C, 24'hFE_DCBA, 8'h81, 4'h8, 4'hF, 1, 1, 1, 0);
        add_entry(0, 4'hF, 3, 9, 0, 0, 0, 4'h9, 4'hF, 1, 1, 1, 1);
        add_entry(1, 4'hF, 3, 9, 32'h5555_AAAA, 24'h33_3333, 8'h7E, 4'hA, 4'hA, 0, 1, 1, 0);
        add_entry(0, 4'hF, 3, 9, 0, 0, 0, 4'hB, 4'hF, 1, 1, 1, 5);
        add_entry(1, 4'h0, 3, 9, 32'hDEAD_BEEF, 24'h00_0001, 8'h01, 4'hC, 4'hF, 1, 1, 1, 0);
        add_entry(0, 4'hA, 3, 9, 0, 0, 0, 4'hD, 4'hF, 1, 1, 1, 0);
        add_entry(0, 4'h6, 40, 30, 0, 0, 0, 4'hE, 4'hF, 1, 1, 1, 4);
        table_built = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check("rsp_valid", 64'(rsp_valid), 64'(1'b0));
        check("cache_req_valid", 64'(c_req_valid), 64'(1'b0));
        check("cache_rsp_ready", 64'(c_rsp_ready), 64'(1'b1));
        @(negedge clk);
        check("req_ready", 64'(req_ready), 64'(1'b1));
        foreach (tbl[k]) run_quad(tbl[k]);
        repeat (4) @(negedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/rop_cache_model.sv ====
module rop_cache_model #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  logic                 req_rw,
    input  logic [3:0]           req_byteen,
    input  logic [31:0]          req_addr,
    input  logic [31:0]          req_data,
    input  logic [TAG_WIDTH-1:0] req_tag,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output logic [31:0]          rsp_data,
    output logic [TAG_WIDTH-1:0] rsp_tag,
    input  logic                 rsp_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        logic [31:0]          data;
        logic [TAG_WIDTH-1:0] tag;
        longint               due;
    } pending_t;

    int          seed = 32'h7320_4387;
    logic [31:0] mem [logic [31:0]];
    pending_t    pend_q[$];
    longint      cycle;
    longint      last_due;

    // Unwritten words read as a hash of the full word address
    function automatic logic [31:0] fill_word(input logic [31:0] waddr);
        return (waddr * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        pending_t    p;
        logic [31:0] waddr;
        logic [31:0] word;
        longint      due;
        if (!arst_n) begin
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_data  <= '0;
            rsp_tag   <= '0;
            cycle     = 0;
            last_due  = 0;
            pend_q.delete();
        end else begin
            cycle = cycle + 1;
            if (req_valid && req_ready) begin
                waddr = req_addr >> 2;
                word  = mem.exists(waddr) ? mem[waddr] : fill_word(waddr);
                if (req_rw) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_byteen[b]) word[8*b +: 8] = req_data[8*b +: 8];
                    end
                    mem[waddr] = word;
                end else begin
                    // Random latency, never earlier than the previous read
                    due = cycle + 1 + ($random(seed) & 7);
                    if (due < last_due) due = last_due;
                    last_due = due;
                    p.data = word;
                    p.tag  = req_tag;
                    p.due  = due;
                    pend_q.push_back(p);
                end
            end
            if (rsp_valid && rsp_ready) void'(pend_q.pop_front());
            if (pend_q.size() > 0 && pend_q[0].due <= cycle) begin
                rsp_valid <= 1'b1;
                rsp_data  <= pend_q[0].data;
                rsp_tag   <= pend_q[0].tag;
            end else begin
                rsp_valid <= 1'b0;
            end
            // Stall roughly one cycle in four
            req_ready <= (($random(seed) & 3) != 0);
        end
    end

endmodule

// ==== rtl/rop_mem_top.sv ====
module rop_mem_top
    import rop_pkg::*;
#(
    parameter  int NUM_LANES       = 4,
    parameter  int TAG_WIDTH       = 4,
    localparam int CACHE_TAG_WIDTH = rop_cache_tag_width(NUM_LANES)
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  rop_dcrs_t                                  dcrs,

    input  logic                                       req_valid,
    input  logic [NUM_LANES-1:0]                       req_tmask,
    input  logic                                       req_rw,
    input  logic [NUM_LANES-1:0][15:0]                 req_pos_x,
    input  logic [NUM_LANES-1:0][15:0]                 req_pos_y,
    input  rgba_t [NUM_LANES-1:0]                      req_color,
    input  logic [NUM_LANES-1:0][ROP_DEPTH_BITS-1:0]   req_depth,
    input  logic [NUM_LANES-1:0][ROP_STENCIL_BITS-1:0] req_stencil,
    input  logic [TAG_WIDTH-1:0]                       req_tag,
    output logic                                       req_ready,

    output logic                                       rsp_valid,
    output logic [NUM_LANES-1:0]                       rsp_tmask,
    output rgba_t [NUM_LANES-1:0]                      rsp_color,
    output logic [NUM_LANES-1:0][ROP_DEPTH_BITS-1:0]   rsp_depth,
    output logic [NUM_LANES-1:0][ROP_STENCIL_BITS-1:0] rsp_stencil,
    output logic [TAG_WIDTH-1:0]                       rsp_tag,
    input  logic                                       rsp_ready,

    output logic                                       cache_req_valid,
    output logic                                       cache_req_rw,
    output logic [ROP_WORD_BYTES-1:0]                  cache_req_byteen,
    output logic [ROP_ADDR_BITS-1:0]                   cache_req_addr,
    output logic [ROP_WORD_BITS-1:0]                   cache_req_data,
    output logic [CACHE_TAG_WIDTH-1:0]                 cache_req_tag,
    input  logic                                       cache_req_ready,

    input  logic                                       cache_rsp_valid,
    input  logic [ROP_WORD_BITS-1:0]                   cache_rsp_data,
    input  logic [CACHE_TAG_WIDTH-1:0]                 cache_rsp_tag,
    output logic                                       cache_rsp_ready
);

    rop_cache_if #(
        .CACHE_TAG_WIDTH (CACHE_TAG_WIDTH)
    ) cache_if ();

    // Cache port flattened onto top-level pins
    assign cache_req_valid    = cache_if.req_valid;
    assign cache_req_rw       = cache_if.req_rw;
    assign cache_req_byteen   = cache_if.req_byteen;
    assign cache_req_addr     = cache_if.req_addr;
    assign cache_req_data     = cache_if.req_data;
    assign cache_req_tag      = cache_if.req_tag;
    assign cache_if.req_ready = cache_req_ready;
    assign cache_if.rsp_valid = cache_rsp_valid;
    assign cache_if.rsp_data  = cache_rsp_data;
    assign cache_if.rsp_tag   = cache_rsp_tag;
    assign cache_rsp_ready    = cache_if.rsp_ready;

    rop_mem #(
        .NUM_LANES   (NUM_LANES),
        .TAG_WIDTH   (TAG_WIDTH)
    ) mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .dcrs        (dcrs),
        .req_valid   (req_valid),
        .req_tmask   (req_tmask),
        .req_rw      (req_rw),
        .req_pos_x   (req_pos_x),
        .req_pos_y   (req_pos_y),
        .req_color   (req_color),
        .req_depth   (req_depth),
        .req_stencil (req_stencil),
        .req_tag     (req_tag),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_tmask   (rsp_tmask),
        .rsp_color   (rsp_color),
        .rsp_depth   (rsp_depth),
        .rsp_stencil (rsp_stencil),
        .rsp_tag     (rsp_tag),
        .rsp_ready   (rsp_ready),
        .cache       (cache_if.master)
    );

endmodule

// ==== rtl/rop_mem.sv ====
module rop_mem
    import rop_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 4
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  rop_dcrs_t                                  dcrs,

    input  logic                                       req_valid,
    input  logic [NUM_LANES-1:0]                       req_tmask,
    input  logic                                       req_rw,
    input  logic [NUM_LANES-1:0][15:0]                 req_pos_x,
    input  logic [NUM_LANES-1:0][15:0]                 req_pos_y,
    input  rgba_t [NUM_LANES-1:0]                      req_color,
    input  logic [NUM_LANES-1:0][ROP_DEPTH_BITS-1:0]   req_depth,
    input  logic [NUM_LANES-1:0][ROP_STENCIL_BITS-1:0] req_stencil,
    input  logic [TAG_WIDTH-1:0]                       req_tag,
    output logic                                       req_ready,

    output logic                                       rsp_valid,
    output logic [NUM_LANES-1:0]                       rsp_tmask,
    output rgba_t [NUM_LANES-1:0]                      rsp_color,
    output logic [NUM_LANES-1:0][ROP_DEPTH_BITS-1:0]   rsp_depth,
    output logic [NUM_LANES-1:0][ROP_STENCIL_BITS-1:0] rsp_stencil,
    output logic [TAG_WIDTH-1:0]                       rsp_tag,
    input  logic                                       rsp_ready,

    rop_cache_if.master                                cache
);

    localparam int NUM_SLOTS = 2 * NUM_LANES;

    // FSM encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ADDR   = 2'd1;
    localparam logic [1:0] ST_STREAM = 2'd2;
    localparam logic [1:0] ST_RESP   = 2'd3;

    logic [1:0]                               state;
    logic                                     load;
    logic                                     start;
    logic                                     done;
    logic                                     rw_r;
    logic [NUM_LANES-1:0]                     tmask_r;
    logic [TAG_WIDTH-1:0]                     tag_r;
    logic [NUM_SLOTS-1:0][ROP_WORD_BITS-1:0]  wdata;
    logic [NUM_SLOTS-1:0][ROP_WORD_BITS-1:0]  rdata;
    logic [NUM_LANES-1:0][ROP_ADDR_BITS-1:0]  color_addr;
    logic [NUM_LANES-1:0][ROP_ADDR_BITS-1:0]  ds_addr;
    logic [ROP_WORD_BYTES-1:0]                color_byteen;
    logic [ROP_WORD_BYTES-1:0]                ds_byteen;
    rop_ds_word_u [NUM_LANES-1:0]             ds_wr;
    rop_ds_word_u [NUM_LANES-1:0]             ds_rd;

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESP);
    assign load      = req_valid && req_ready;
    // Addresses are ready in the cycle after load
    assign start     = (state == ST_ADDR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            rw_r    <= 1'b0;
            tmask_r <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        rw_r    <= req_rw;
                        tmask_r <= req_tmask;
                        state   <= ST_ADDR;
                    end
                end
                ST_ADDR:   state <= ST_STREAM;
                ST_STREAM: if (done) state <= ST_RESP;
                ST_RESP:   if (rsp_ready) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Pack write words, unpack read words
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            ds_wr[i].fields.depth   = req_depth[i];
            ds_wr[i].fields.stencil = req_stencil[i];
            ds_rd[i].raw            = rdata[2*i+1];
            rsp_color[i]            = rdata[2*i];
            rsp_depth[i]            = ds_rd[i].fields.depth;
            rsp_stencil[i]          = ds_rd[i].fields.stencil;
        end
    end

    // Quad payload, captured on accept
    always_ff @(posedge clk) begin
        if (load) begin
            tag_r <= req_tag;
            for (int i = 0; i < NUM_LANES; i++) begin
                wdata[2*i]   <= req_color[i];
                wdata[2*i+1] <= ds_wr[i].raw;
            end
        end
    end

    assign rsp_tmask = tmask_r;
    assign rsp_tag   = tag_r;

    rop_addr_gen #(
        .NUM_LANES    (NUM_LANES)
    ) addr_gen (
        .clk          (clk),
        .arst_n       (arst_n),
        .load         (load),
        .dcrs         (dcrs),
        .pos_x        (req_pos_x),
        .pos_y        (req_pos_y),
        .color_addr   (color_addr),
        .ds_addr      (ds_addr),
        .color_byteen (color_byteen),
        .ds_byteen    (ds_byteen)
    );

    rop_mem_streamer #(
        .NUM_LANES    (NUM_LANES)
    ) streamer (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .rw           (rw_r),
        .tmask        (tmask_r),
        .color_addr   (color_addr),
        .ds_addr      (ds_addr),
        .color_byteen (color_byteen),
        .ds_byteen    (ds_byteen),
        .wdata        (wdata),
        .done         (done),
        .rdata        (rdata),
        .cache        (cache)
    );

    // Response holds while the consumer stalls
    assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid
            && $stable({rsp_tmask, rsp_color, rsp_depth, rsp_stencil, rsp_tag}));

endmodule

// ==== rtl/rop_mem_streamer.sv ====
module rop_mem_streamer
    import rop_pkg::*;
#(
    parameter  int NUM_LANES       = 4,
    localparam int CACHE_TAG_WIDTH = rop_cache_tag_width(NUM_LANES),
    localparam int NUM_SLOTS       = 2 * NUM_LANES
) (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    start,
    input  logic                                    rw,
    input  logic [NUM_LANES-1:0]                    tmask,
    input  logic [NUM_LANES-1:0][ROP_ADDR_BITS-1:0] color_addr,
    input  logic [NUM_LANES-1:0][ROP_ADDR_BITS-1:0] ds_addr,
    input  logic [ROP_WORD_BYTES-1:0]               color_byteen,
    input  logic [ROP_WORD_BYTES-1:0]               ds_byteen,
    input  logic [NUM_SLOTS-1:0][ROP_WORD_BITS-1:0] wdata,
    output logic                                    done,
    output logic [NUM_SLOTS-1:0][ROP_WORD_BITS-1:0] rdata,
    rop_cache_if.master                             cache
);

    localparam int SLOT_BITS = $clog2(NUM_SLOTS);

    // Slot s covers lane s/2, even slot is color, odd slot is depth-stencil
    logic                       busy;
    logic [CACHE_TAG_WIDTH-1:0] ptr;
    logic [CACHE_TAG_WIDTH-1:0] cur;
    logic                       found;
    logic [NUM_SLOTS-1:0]       outstanding;
    logic [NUM_SLOTS-1:0]       set_vec;
    logic [NUM_SLOTS-1:0]       clr_vec;
    logic                       req_fire;
    logic                       rsp_fire;
    logic [SLOT_BITS-1:0]       cur_slot;
    logic [SLOT_BITS-1:0]       rsp_slot;

    // Next active slot at or after the pointer, lowest index wins
    always_comb begin
        found = 1'b0;
        cur   = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (s >= int'(ptr) && tmask[s / 2]) begin
                found = 1'b1;
                cur   = CACHE_TAG_WIDTH'(s);
            end
        end
    end

    assign cur_slot = cur[SLOT_BITS-1:0];
    assign rsp_slot = cache.rsp_tag[SLOT_BITS-1:0];

    // Cache request straight from the current slot
    assign cache.req_valid  = busy && found;
    assign cache.req_rw     = rw;
    assign cache.req_tag    = cur;
    assign cache.req_data   = wdata[cur_slot];
    assign cache.req_addr   = cur_slot[0] ? ds_addr[cur_slot[SLOT_BITS-1:1]]
                                          : color_addr[cur_slot[SLOT_BITS-1:1]];
    assign cache.req_byteen = cur_slot[0] ? ds_byteen : color_byteen;

    // Responses are always taken, slots are reserved at issue
    assign cache.rsp_ready = 1'b1;

    assign req_fire = cache.req_valid && cache.req_ready;
    assign rsp_fire = cache.rsp_valid && cache.rsp_ready;

    // Pending read bookkeeping
    assign set_vec = (req_fire && !rw) ? (NUM_SLOTS'(1) << cur_slot) : '0;
    assign clr_vec = rsp_fire ? (NUM_SLOTS'(1) << rsp_slot) : '0;

    // Walk finished and nothing in flight
    assign done = busy && !found && (outstanding == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy        <= 1'b0;
            ptr         <= '0;
            outstanding <= '0;
        end else begin
            if (start) begin
                busy <= 1'b1;
                ptr  <= '0;
            end else if (done) begin
                busy <= 1'b0;
            end else if (req_fire) begin
                ptr <= cur + 1'b1;
            end
            outstanding <= (outstanding | set_vec) & ~clr_vec;
        end
    end

    // Collect buffer, cleared as each quad starts so idle lanes read zero
    always_ff @(posedge clk) begin
        if (start) begin
            rdata <= '0;
        end else if (rsp_fire) begin
            rdata[rsp_slot] <= cache.rsp_data;
        end
    end

    // Every returned tag names a read still in flight
    assert property (@(posedge clk) disable iff (!arst_n)
        cache.rsp_valid |-> (int'(cache.rsp_tag) < NUM_SLOTS) && outstanding[rsp_slot]);

    // A stalled request keeps its contents until accepted
    assert property (@(posedge clk) disable iff (!arst_n)
        cache.req_valid && !cache.req_ready |=> cache.req_valid
            && $stable({cache.req_rw, cache.req_byteen, cache.req_addr,
                        cache.req_data, cache.req_tag}));

endmodule

// ==== rtl/rop_addr_gen.sv ====
module rop_addr_gen
    import rop_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    load,
    input  rop_dcrs_t                               dcrs,
    input  logic [NUM_LANES-1:0][15:0]              pos_x,
    input  logic [NUM_LANES-1:0][15:0]              pos_y,
    output logic [NUM_LANES-1:0][ROP_ADDR_BITS-1:0] color_addr,
    output logic [NUM_LANES-1:0][ROP_ADDR_BITS-1:0] ds_addr,
    output logic [ROP_WORD_BYTES-1:0]               color_byteen,
    output logic [ROP_WORD_BYTES-1:0]               ds_byteen
);

    // Byte address of pixel (x, y) in a buffer with pitch in pixels
    function automatic logic [ROP_ADDR_BITS-1:0] pixel_addr(
        input logic [ROP_ADDR_BITS-1:0] base,
        input logic [15:0]              pitch,
        input logic [15:0]              x,
        input logic [15:0]              y
    );
        logic [ROP_ADDR_BITS-1:0] offset;
        offset = ROP_ADDR_BITS'(y) * ROP_ADDR_BITS'(pitch) + ROP_ADDR_BITS'(x);
        // One 4-byte word per pixel
        return base + (offset << 2);
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            color_addr   <= '0;
            ds_addr      <= '0;
            color_byteen <= '0;
            ds_byteen    <= '0;
        end else if (load) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                color_addr[i] <= pixel_addr(dcrs.cbuf_addr, dcrs.cbuf_pitch,
                                            pos_x[i], pos_y[i]);
                ds_addr[i]    <= pixel_addr(dcrs.zbuf_addr, dcrs.zbuf_pitch,
                                            pos_x[i], pos_y[i]);
            end
            // One enable per color channel
            color_byteen <= dcrs.cbuf_writemask;
            // Stencil in the top byte, depth in the low three
            ds_byteen    <= {dcrs.zbuf_stencil_writemask, {3{dcrs.zbuf_depth_writemask}}};
        end
    end

endmodule

// ==== rtl/rop_cache_if.sv ====
interface rop_cache_if
    import rop_pkg::*;
#(
    parameter int CACHE_TAG_WIDTH = 4
);

    // Request channel
    logic                       req_valid;
    logic                       req_rw;
    logic [ROP_WORD_BYTES-1:0]  req_byteen;
    logic [ROP_ADDR_BITS-1:0]   req_addr;
    logic [ROP_WORD_BITS-1:0]   req_data;
    logic [CACHE_TAG_WIDTH-1:0] req_tag;
    logic                       req_ready;

    // Response channel, reads only
    logic                       rsp_valid;
    logic [ROP_WORD_BITS-1:0]   rsp_data;
    logic [CACHE_TAG_WIDTH-1:0] rsp_tag;
    logic                       rsp_ready;

    modport master (
        output req_valid, req_rw, req_byteen, req_addr, req_data, req_tag,
        input  req_ready,
        input  rsp_valid, rsp_data, rsp_tag,
        output rsp_ready
    );

    modport slave (
        input  req_valid, req_rw, req_byteen, req_addr, req_data, req_tag,
        output req_ready,
        output rsp_valid, rsp_data, rsp_tag,
        input  rsp_ready
    );

endinterface

// ==== rtl/rop_pkg.sv ====
package rop_pkg;

    // Memory word and address geometry
    localparam int ROP_ADDR_BITS  = 32;
    localparam int ROP_WORD_BITS  = 32;
    localparam int ROP_WORD_BYTES = ROP_WORD_BITS / 8;

    // Depth and stencil share one memory word
    localparam int ROP_DEPTH_BITS   = 24;
    localparam int ROP_STENCIL_BITS = 8;

    // Red in the low byte, so byte enable n maps to one channel
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] g;
        logic [7:0] r;
    } rgba_t;

    // Depth-stencil word, seen as raw cache data or as its two fields
    typedef union packed {
        logic [ROP_WORD_BITS-1:0] raw;
        struct packed {
            logic [ROP_STENCIL_BITS-1:0] stencil;
            logic [ROP_DEPTH_BITS-1:0]   depth;
        } fields;
    } rop_ds_word_u;

    // Device configuration registers
    typedef struct packed {
        logic [ROP_ADDR_BITS-1:0] cbuf_addr;
        logic [15:0]              cbuf_pitch;
        logic [3:0]               cbuf_writemask;
        logic [ROP_ADDR_BITS-1:0] zbuf_addr;
        logic [15:0]              zbuf_pitch;
        logic                     zbuf_depth_writemask;
        logic                     zbuf_stencil_writemask;
    } rop_dcrs_t;

    // Bits needed to count up to 2*num_lanes access slots
    // The streamer pointer also reaches this count when it is finished
    function automatic int rop_cache_tag_width(input int num_lanes);
        return $clog2(2 * num_lanes + 1);
    endfunction

endpackage
